// ==== uart_report.f ====
+incdir+hdl
hdl/uart_report_pkg.sv
hdl/report_fsm.sv
hdl/char_counter.sv
hdl/hex_ascii_encoder.sv
hdl/char_shift_reg.sv
hdl/uart_report_top.sv
test/uart_report_tb.sv

// ==== test/uart_report_tb.sv ====
// Directed testbench for the hex report line generator; drives triggers and checks each line

`timescale 1ns/1ps

`include "uart_report_params.svh"

module uart_report_tb;

    import uart_report_pkg::*;

    // Six reports of 20 bytes at up to 12 cycles per byte plus a wide margin
    localparam int REPORTS         = 6;
    localparam int LINE_BYTES      = 20;
    localparam int BYTE_CYCLES_MAX = 12;
    localparam int TIMEOUT_CYCLES  = REPORTS * LINE_BYTES * BYTE_CYCLES_MAX * 4 + 240;

    // Uppercase hex digits with '0' in the top byte
    localparam logic [8*16-1:0] HEX_DIGITS = "0123456789ABCDEF";

    logic                  CLK = 1'b0;
    logic                  RST_N;
    logic                  trig;
    logic                  out_sel;
    report_inputs_t        values;
    logic                  tx_busy = 1'b0;
    logic                  busy;
    logic                  de;
    logic [`CHAR_W-1:0]    data;

    logic [`CHAR_W-1:0]    rx_q[$];
    logic [`CHAR_W-1:0]    exp_q[$];
    int                    errors = 0;
    int                    checks = 0;
    int                    tests_run = 0;
    int                    cycle_cnt = 0;

    uart_report_top uut (
        .CLK     (CLK),
        .RST_N   (RST_N),
        .trig    (trig),
        .out_sel (out_sel),
        .values  (values),
        .tx_busy (tx_busy),
        .busy    (busy),
        .de      (de),
        .data    (data)
    );

    always #5 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Run stopped: no result after %0d clock cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Transmitter model logs each byte as it goes busy
    // ----------------------------------------------------------------------
    always begin : tx_model
        int delay;
        int hold;
        @(negedge CLK);
        if (RST_N === 1'b1 && de === 1'b1) begin
            delay = $urandom_range(3, 1);
            hold  = $urandom_range(6, 2);
            repeat (delay) @(negedge CLK);
            tx_busy = 1'b1;
            rx_q.push_back(data);
            repeat (hold) @(negedge CLK);
            tx_busy = 1'b0;
        end
    end

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    function automatic logic [7:0] hex_char(input logic [3:0] nib);
        return HEX_DIGITS[(15 - int'(nib)) * 8 +: 8];
    endfunction

    task automatic push_hex(input logic [27:0] val, input int digits);
        for (int i = digits - 1; i >= 0; i--) begin
            exp_q.push_back(hex_char(val[i*4 +: 4]));
        end
    endtask

    // Expected line is S then sums or centroids then LF
    task automatic build_line(input report_inputs_t v, input logic mode);
        logic [27:0] c_x;
        logic [27:0] c_y;
        c_x = {v.quot_sx[11:0], v.frac_sx[19:4]};
        c_y = {v.quot_sy[11:0], v.frac_sy[19:4]};
        exp_q.delete();
        push_hex({8'h00, v.sum_s}, 5);
        if (mode) begin
            push_hex(c_x, 7);
            push_hex(c_y, 7);
        end else begin
            push_hex(v.sum_sx, 7);
            push_hex(v.sum_sy, 7);
        end
        exp_q.push_back(8'h0A);
    endtask

    task automatic compare_line();
        check_eq("byte count", rx_q.size(), exp_q.size());
        for (int i = 0; i < rx_q.size() && i < exp_q.size(); i++) begin
            check_eq($sformatf("byte %0d", i), rx_q[i], exp_q[i]);
        end
    endtask

    function automatic report_inputs_t random_values();
        logic [191:0] r;
        r = {$urandom(), $urandom(), $urandom(), $urandom(), $urandom(), $urandom()};
        return r[$bits(report_inputs_t)-1:0];
    endfunction

    task automatic wait_idle();
        while (busy) @(negedge CLK);
    endtask

    task automatic end_test(input string name, input int err0);
        tests_run++;
        if (errors == err0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - err0);
        end
    endtask

    // One trigger pulse with the inputs scrambled afterwards
    task automatic run_report(input report_inputs_t v, input logic mode);
        build_line(v, mode);
        rx_q.delete();
        @(negedge CLK);
        values  = v;
        out_sel = mode;
        trig    = 1'b1;
        @(negedge CLK);
        trig    = 1'b0;
        values  = random_values();
        out_sel = ~mode;
        check_eq("busy after trigger", busy, 1'b1);
        wait_idle();
        compare_line();
        check_eq("data idle after line", data, `CHAR_IDLE);
        check_eq("de low after line", de, 1'b0);
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------
    task automatic reset_test();
        int err0;
        err0 = errors;
        check_eq("de after reset", de, 1'b0);
        check_eq("busy after reset", busy, 1'b0);
        check_eq("data after reset", data, `CHAR_IDLE);
        end_test("reset state", err0);
    endtask

    task automatic sums_test();
        report_inputs_t v;
        int err0;
        err0 = errors;
        v = '0;
        v.sum_s  = 20'hA5C31;
        v.sum_sx = 28'h0123456;
        v.sum_sy = 28'hFEDCBA9;
        run_report(v, 1'b0);
        end_test("mode 0 sums", err0);
    endtask

    task automatic centroid_test();
        report_inputs_t v;
        int err0;
        err0 = errors;
        v = '0;
        v.sum_s   = 20'h0F00D;
        v.quot_sx = 28'h7654ABC;
        v.frac_sx = 20'h9E3D7;
        v.quot_sy = 28'hFFF0F01;
        v.frac_sy = 20'h1234F;
        run_report(v, 1'b1);
        end_test("mode 1 centroids", err0);
    endtask

    task automatic held_trigger_test();
        report_inputs_t v;
        int err0;
        err0 = errors;
        v = random_values();
        build_line(v, 1'b0);
        rx_q.delete();
        @(negedge CLK);
        values  = v;
        out_sel = 1'b0;
        trig    = 1'b1;
        @(negedge CLK);
        check_eq("busy after trigger", busy, 1'b1);
        values  = random_values();
        out_sel = 1'b1;
        while (rx_q.size() < 4) @(negedge CLK);
        // Edges during the report must be ignored
        repeat (3) begin
            @(negedge CLK);
            trig = 1'b0;
            @(negedge CLK);
            trig = 1'b1;
        end
        wait_idle();
        check_eq("bytes when busy fell", rx_q.size(), LINE_BYTES);
        repeat (40) @(negedge CLK);
        check_eq("busy with trigger held", busy, 1'b0);
        compare_line();
        trig = 1'b0;
        @(negedge CLK);
        end_test("held and repeated trigger", err0);
    endtask

    task automatic random_test();
        int err0;
        err0 = errors;
        for (int n = 0; n < 3; n++) begin
            run_report(random_values(), 1'($urandom_range(1, 0)));
        end
        end_test("back-to-back random reports", err0);
    endtask

    initial begin
        void'($urandom(32'hf365f2ad));
        RST_N   = 1'b0;
        trig    = 1'b0;
        out_sel = 1'b0;
        values  = '0;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RST_N = 1'b1;

        reset_test();
        sums_test();
        centroid_test();
        held_trigger_test();
        random_test();

        $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== hdl/uart_report_top.sv ====
// Top level of the hex report line generator: input snapshot, encoders, sequencer and shifter

`timescale 1ns/1ps

`include "uart_report_params.svh"

module uart_report_top (
    input  logic                            CLK,
    input  logic                            RST_N,
    input  logic                            trig,
    input  logic                            out_sel,
    input  uart_report_pkg::report_inputs_t values,
    input  logic                            tx_busy,
    output logic                            busy,
    output logic                            de,
    output logic [`CHAR_W-1:0]              data
);

    import uart_report_pkg::*;

    report_inputs_t                 snap;
    logic                           mode_q;
    logic                           start;
    logic                           load;
    logic                           shift;
    logic                           last;
    field_e                         field;
    logic [`SUM_XY_W-1:0]           cent_sx;
    logic [`SUM_XY_W-1:0]           cent_sy;
    logic [`CHAR_W*`S_DIGITS-1:0]   ascii_s;
    logic [`CHAR_W*`XY_DIGITS-1:0]  ascii_sx;
    logic [`CHAR_W*`XY_DIGITS-1:0]  ascii_sy;
    logic [`CHAR_W*`XY_DIGITS-1:0]  ascii_qsx;
    logic [`CHAR_W*`XY_DIGITS-1:0]  ascii_qsy;

    // ----------------------------------------------------------------------
    // Snapshot on the start pulse
    // ----------------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (start) begin
            snap <= values;
        end
    end

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            mode_q <= 1'b0;
        end else if (start) begin
            mode_q <= out_sel;
        end
    end

    // Centroid in fixed point, integer part then fraction
    assign cent_sx = {snap.quot_sx[`QUOT_KEEP_W-1:0], snap.frac_sx[`FRAC_W-1 -: `FRAC_KEEP_W]};
    assign cent_sy = {snap.quot_sy[`QUOT_KEEP_W-1:0], snap.frac_sy[`FRAC_W-1 -: `FRAC_KEEP_W]};

    // ----------------------------------------------------------------------
    // Encoders
    // ----------------------------------------------------------------------
    hex_ascii_encoder #(.DIGITS(`S_DIGITS)) u_enc_s (
        .CLK   (CLK),
        .RST_N (RST_N),
        .value (snap.sum_s),
        .ascii (ascii_s)
    );

    hex_ascii_encoder #(.DIGITS(`XY_DIGITS)) u_enc_sx (
        .CLK   (CLK),
        .RST_N (RST_N),
        .value (snap.sum_sx),
        .ascii (ascii_sx)
    );

    hex_ascii_encoder #(.DIGITS(`XY_DIGITS)) u_enc_sy (
        .CLK   (CLK),
        .RST_N (RST_N),
        .value (snap.sum_sy),
        .ascii (ascii_sy)
    );

    hex_ascii_encoder #(.DIGITS(`XY_DIGITS)) u_enc_qsx (
        .CLK   (CLK),
        .RST_N (RST_N),
        .value (cent_sx),
        .ascii (ascii_qsx)
    );

    hex_ascii_encoder #(.DIGITS(`XY_DIGITS)) u_enc_qsy (
        .CLK   (CLK),
        .RST_N (RST_N),
        .value (cent_sy),
        .ascii (ascii_qsy)
    );

    // ----------------------------------------------------------------------
    // Sequencer, counter and output shifter
    // ----------------------------------------------------------------------
    report_fsm u_fsm (
        .CLK     (CLK),
        .RST_N   (RST_N),
        .trig    (trig),
        .mode    (mode_q),
        .tx_busy (tx_busy),
        .last    (last),
        .start   (start),
        .field   (field),
        .load    (load),
        .shift   (shift),
        .busy    (busy),
        .de      (de)
    );

    char_counter u_cnt (
        .CLK   (CLK),
        .RST_N (RST_N),
        .load  (load),
        .field (field),
        .shift (shift),
        .last  (last)
    );

    char_shift_reg u_shift (
        .CLK       (CLK),
        .RST_N     (RST_N),
        .load      (load),
        .field     (field),
        .shift     (shift),
        .ascii_s   (ascii_s),
        .ascii_sx  (ascii_sx),
        .ascii_sy  (ascii_sy),
        .ascii_qsx (ascii_qsx),
        .ascii_qsy (ascii_qsy),
        .data      (data)
    );

endmodule

// ==== hdl/char_shift_reg.sv ====
// Holds the characters of the current field and presents them one at a time on data

`timescale 1ns/1ps

`include "uart_report_params.svh"

module char_shift_reg (
    input  logic                              CLK,
    input  logic                              RST_N,
    input  logic                              load,
    input  uart_report_pkg::field_e           field,
    input  logic                              shift,
    input  logic [`CHAR_W*`S_DIGITS-1:0]      ascii_s,
    input  logic [`CHAR_W*`XY_DIGITS-1:0]     ascii_sx,
    input  logic [`CHAR_W*`XY_DIGITS-1:0]     ascii_sy,
    input  logic [`CHAR_W*`XY_DIGITS-1:0]     ascii_qsx,
    input  logic [`CHAR_W*`XY_DIGITS-1:0]     ascii_qsy,
    output logic [`CHAR_W-1:0]                data
);

    import uart_report_pkg::*;

    localparam int HOLD_W = `CHAR_W * `HOLD_CHARS;

    // Top byte is the character on data, idle code fills from the bottom
    logic [HOLD_W-1:0] hold;

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            hold <= {`HOLD_CHARS{`CHAR_IDLE}};
        end else if (load) begin
            case (field)
                FIELD_S:   hold <= {ascii_s, {(`HOLD_CHARS - `S_DIGITS){`CHAR_IDLE}}};
                FIELD_SX:  hold <= ascii_sx;
                FIELD_SY:  hold <= ascii_sy;
                FIELD_QSX: hold <= ascii_qsx;
                FIELD_QSY: hold <= ascii_qsy;
                default:   hold <= {`CHAR_LF, {(`HOLD_CHARS - 1){`CHAR_IDLE}}};
            endcase
        end else if (shift) begin
            hold <= {hold[HOLD_W-`CHAR_W-1:0], `CHAR_IDLE};
        end
    end

    assign data = hold[HOLD_W-1 -: `CHAR_W];

endmodule

// ==== hdl/hex_ascii_encoder.sv ====
// Registered binary to uppercase ASCII hex converter, most significant digit in the top byte

`timescale 1ns/1ps

`include "uart_report_params.svh"

module hex_ascii_encoder #(
    parameter int DIGITS = 7
) (
    input  logic                         CLK,
    input  logic                         RST_N,
    input  logic [`NIBBLE_W*DIGITS-1:0]  value,
    output logic [`CHAR_W*DIGITS-1:0]    ascii
);

    logic [`CHAR_W*DIGITS-1:0] ascii_nxt;

    function automatic logic [`CHAR_W-1:0] to_ascii(input logic [`NIBBLE_W-1:0] nib);
        logic [`CHAR_W-1:0] code;
        if (nib < 4'd10) begin
            code = `CHAR_ZERO + {4'h0, nib};
        end else begin
            code = `CHAR_UPPER_A + {4'h0, nib - 4'd10};
        end
        return code;
    endfunction

    // Digit i lands in byte i, so the top nibble is sent first
    always_comb begin
        for (int i = 0; i < DIGITS; i++) begin
            ascii_nxt[i*`CHAR_W +: `CHAR_W] = to_ascii(value[i*`NIBBLE_W +: `NIBBLE_W]);
        end
    end

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            ascii <= '0;
        end else begin
            ascii <= ascii_nxt;
        end
    end

endmodule

// ==== hdl/char_counter.sv ====
// Counts the characters still to be sent in the current field and flags the final one

`timescale 1ns/1ps

`include "uart_report_params.svh"

module char_counter (
    input  logic                    CLK,
    input  logic                    RST_N,
    input  logic                    load,
    input  uart_report_pkg::field_e field,
    input  logic                    shift,
    output logic                    last
);

    import uart_report_pkg::*;

    localparam int CNT_W = $clog2(`HOLD_CHARS);

    // Characters left after the one on data
    logic [CNT_W-1:0] remain;

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            remain <= '0;
        end else if (load) begin
            case (field)
                FIELD_S:  remain <= CNT_W'(`S_DIGITS - 1);
                FIELD_LF: remain <= '0;
                default:  remain <= CNT_W'(`XY_DIGITS - 1);
            endcase
        end else if (shift && remain != '0) begin
            remain <= remain - 1'b1;
        end
    end

    assign last = (remain == '0);

endmodule

// ==== hdl/report_fsm.sv ====
// Report sequencer: starts on a trigger edge, steps through the fields and runs the byte handshake

`timescale 1ns/1ps

module report_fsm (
    input  logic                    CLK,
    input  logic                    RST_N,
    input  logic                    trig,
    input  logic                    mode,
    input  logic                    tx_busy,
    input  logic                    last,
    output logic                    start,
    output uart_report_pkg::field_e field,
    output logic                    load,
    output logic                    shift,
    output logic                    busy,
    output logic                    de
);

    import uart_report_pkg::*;

    fsm_state_e state;
    fsm_state_e state_nxt;
    field_e     field_q;
    field_e     field_nxt;
    logic       trig_q;

    // Field order depends on the mode captured with the data
    function automatic field_e following(input field_e cur, input logic sel);
        field_e nxt;
        case (cur)
            FIELD_S:   nxt = sel ? FIELD_QSX : FIELD_SX;
            FIELD_SX:  nxt = FIELD_SY;
            FIELD_QSX: nxt = FIELD_QSY;
            default:   nxt = FIELD_LF;
        endcase
        return nxt;
    endfunction

    // ----------------------------------------------------------------------
    // Trigger edge, accepted only while idle
    // ----------------------------------------------------------------------
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            trig_q <= 1'b0;
        end else begin
            trig_q <= trig;
        end
    end

    assign start = trig & ~trig_q & (state == IDLE);

    // ----------------------------------------------------------------------
    // State and field registers
    // ----------------------------------------------------------------------
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state   <= IDLE;
            field_q <= FIELD_S;
        end else begin
            state   <= state_nxt;
            field_q <= field_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        field_nxt = field_q;
        load      = 1'b0;
        shift     = 1'b0;
        case (state)
            IDLE: begin
                if (start) begin
                    state_nxt = NEXT;
                    field_nxt = FIELD_S;
                end
            end
            // Snapshot passes through the encoders here
            NEXT: begin
                state_nxt = LOAD;
            end
            LOAD: begin
                load      = 1'b1;
                state_nxt = SEND;
            end
            SEND: begin
                if (tx_busy) begin
                    state_nxt = WAIT_TX;
                end
            end
            WAIT_TX: begin
                if (!tx_busy) begin
                    if (!last) begin
                        shift     = 1'b1;
                        state_nxt = SEND;
                    end else if (field_q == FIELD_LF) begin
                        // Shifting past the LF puts the idle code back on data
                        shift     = 1'b1;
                        state_nxt = IDLE;
                    end else begin
                        // Next field loads now so its first byte goes out next cycle
                        field_nxt = following(field_q, mode);
                        load      = 1'b1;
                        state_nxt = SEND;
                    end
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    assign field = field_nxt;
    assign busy  = (state != IDLE);
    assign de    = (state == SEND);

endmodule

// ==== hdl/uart_report_pkg.sv ====
// Types shared by the report line RTL: input snapshot struct, field and FSM state enumerations

`include "uart_report_params.svh"

package uart_report_pkg;

    // ----------------------------------------------------------------------
    // Accumulator results presented at the trigger
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [`SUM_S_W-1:0]    sum_s;
        logic [`SUM_XY_W-1:0]   sum_sx;
        logic [`SUM_XY_W-1:0]   sum_sy;
        // Divider outputs for the centroids
        logic [`SUM_XY_W-1:0]   quot_sx;
        logic [`SUM_XY_W-1:0]   quot_sy;
        logic [`FRAC_W-1:0]     frac_sx;
        logic [`FRAC_W-1:0]     frac_sy;
    } report_inputs_t;

    // ----------------------------------------------------------------------
    // Parts of one output line
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        FIELD_S   = 3'd0,
        FIELD_SX  = 3'd1,
        FIELD_SY  = 3'd2,
        FIELD_QSX = 3'd3,
        FIELD_QSY = 3'd4,
        FIELD_LF  = 3'd5
    } field_e;

    // Sequencer states
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        LOAD    = 3'd1,
        SEND    = 3'd2,
        WAIT_TX = 3'd3,
        NEXT    = 3'd4
    } fsm_state_e;

endpackage

// ==== hdl/uart_report_params.svh ====
// Widths, digit counts and character codes shared by the report line RTL; include where needed

`ifndef UART_REPORT_PARAMS_SVH
`define UART_REPORT_PARAMS_SVH

// ----------------------------------------------------------------------
// Data widths
// ----------------------------------------------------------------------
`define CHAR_W          8
`define NIBBLE_W        4
`define SUM_S_W         20
`define SUM_XY_W        28
`define FRAC_W          20

// Centroid is quotient low bits followed by fraction high bits
`define QUOT_KEEP_W     12
`define FRAC_KEEP_W     16

// ----------------------------------------------------------------------
// Field lengths in characters
// ----------------------------------------------------------------------
`define S_DIGITS        5
`define XY_DIGITS       7
`define HOLD_CHARS      7

// ----------------------------------------------------------------------
// Character codes
// ----------------------------------------------------------------------
`define CHAR_LF         8'h0A
`define CHAR_IDLE       8'hFF
`define CHAR_ZERO       8'h30
`define CHAR_UPPER_A    8'h41

`endif
